// ==== filelist.f ====
common/busPkg.sv
common/dramPkg.sv
hdl/AddrDecode.sv
hdl/RefreshTimer.sv
dram/DramCtrl.sv
hdl/MemSubsys.sv
testbench/MemSubsys_props.sv
testbench/tb_MemSubsys.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

rm -rf "$OBJ"
if ! verilator --binary --timing --assert -f filelist.f --top-module tb_MemSubsys -Mdir "$OBJ"; then
	echo "Build failed"
	exit 1
fi

if ! "./$OBJ/Vtb_MemSubsys" > "$LOG" 2>&1; then
	echo "Simulation exited with an error, see $LOG"
	exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see $LOG"
	exit 1
fi

// ==== testbench/tb_MemSubsys.sv ====
module tb_MemSubsys;
	import busPkg::*;
	import dramPkg::*;

	localparam int ReadyTimeout = 40; // Half cycles
	localparam int RamFree = AddrHi - AddrLo + 1 - RamSelBits;
	// Address bit carried by each RA pin, RA0 first
	localparam int RowSrc [0:11] = '{9, 10, 16, 19, 11, 12, 13, 14, 18, 15, 17, 19};
	localparam int ColSrc [0:11] = '{1, 2, 7, 20, 3, 4, 5, 6, 21, 8, 7, 20};

	logic CLK;
	logic reset;
	logic [AddrHi:AddrLo] A;
	logic nAS;
	logic nWE;
	logic nLDS;
	logic nUDS;
	logic RAMReady;
	logic [RaWidth-1:0] RA;
	logic nRAS;
	logic nCAS;
	logic nLWE;
	logic nUWE;
	logic nOE;
	logic nROMCS;
	logic nROMWE;

	logic [31:0] lfsr;
	int unsigned cycCnt; // Mirrors the refresh interval counter
	int rowHits;
	int colHits;
	int lweLow;
	int uweLow;

	MemSubsys i_MemSubsys (
		.CLK      (CLK),
		.reset    (reset),
		.A        (A),
		.nAS      (nAS),
		.nWE      (nWE),
		.nLDS     (nLDS),
		.nUDS     (nUDS),
		.RAMReady (RAMReady),
		.RA       (RA),
		.nRAS     (nRAS),
		.nCAS     (nCAS),
		.nLWE     (nLWE),
		.nUWE     (nUWE),
		.nOE      (nOE),
		.nROMCS   (nROMCS),
		.nROMWE   (nROMWE)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		if (reset) begin
			cycCnt <= 0;
		end else begin
			cycCnt <= cycCnt + 1;
		end
	end

	task automatic abortRun();
		$display("RESULT: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic failWith(input string why);
		$display("Test stopped: %s", why);
		abortRun();
	endtask

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s = 0x%0h, expected 0x%0h", name, got, exp);
			abortRun();
		end
	endtask

	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? 32'hA3000000 : 32'h0); // Galois form with taps 32 30 26 25
	endfunction

	task automatic takeBits(input int count, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < count; i++) begin
			v[i] = lfsr[0];
			lfsr = lfsrStep(lfsr);
		end
	endtask

	function automatic logic [RaWidth-1:0] rowOf(input logic [AddrHi:AddrLo] a);
		logic [RaWidth-1:0] r;
		for (int i = 0; i < RaWidth; i++) begin
			r[i] = a[RowSrc[i]];
		end
		return r;
	endfunction

	function automatic logic [RaWidth-1:0] colOf(input logic [AddrHi:AddrLo] a);
		logic [RaWidth-1:0] c;
		for (int i = 0; i < RaWidth; i++) begin
			c[i] = a[ColSrc[i]];
		end
		return c;
	endfunction

	function automatic int refPhase();
		return int'(cycCnt % RefPeriod);
	endfunction

	// Next clock edge, then let it settle
	task automatic halfStep();
		@(CLK);
		#2;
	endtask

	// Park on a falling edge far enough from any refresh window
	task automatic waitQuiet(input int span);
		int n;
		n = 0;
		@(negedge CLK);
		while (refPhase() < 2 || refPhase() > RefReqAt - span) begin
			if (n == 2 * RefPeriod) failWith("no refresh-free window came up");
			@(negedge CLK);
			n++;
		end
	endtask

	task automatic releaseBus();
		int n;
		@(negedge CLK);
		nAS = 1'b1;
		n = 0;
		#2;
		while (RAMReady !== 1'b0) begin
			if (n == 4) failWith("RAMReady still high two cycles after nAS rose");
			halfStep();
			n++;
		end
		repeat (6) halfStep(); // Recover and back to Idle
		@(negedge CLK);
		A = '0;
		nWE = 1'b1;
		nLDS = 1'b1;
		nUDS = 1'b1;
	endtask

	task automatic watchRam(input logic [AddrHi:AddrLo] addr, input logic wr,
			input logic ldsN, input logic udsN);
		if (wr) begin
			checkEq("nOE", 32'(nOE), 1);
			if (!RAMReady) begin // RAM still enabled before the access starts
				checkEq("nLWE", 32'(nLWE), 32'(nAS | ldsN));
				checkEq("nUWE", 32'(nUWE), 32'(nAS | udsN));
			end
			if (ldsN) checkEq("nLWE", 32'(nLWE), 1);
			if (udsN) checkEq("nUWE", 32'(nUWE), 1);
			if (!nLWE) lweLow++;
			if (!nUWE) uweLow++;
		end else begin
			checkEq("nOE", 32'(nOE), 32'(nAS));
			checkEq("nLWE", 32'(nLWE), 1);
			checkEq("nUWE", 32'(nUWE), 1);
		end
		if (!nRAS && nCAS && !RAMReady) begin
			checkEq("RA (row)", 32'(RA), 32'(rowOf(addr)));
			rowHits++;
		end
		if (!nRAS && !nCAS) begin
			checkEq("RA (column)", 32'(RA), 32'(colOf(addr)));
			colHits++;
		end
	endtask

	task automatic ramAccess(input logic [AddrHi:AddrLo] addr, input logic wr,
			input logic ldsN, input logic udsN);
		int n;
		rowHits = 0;
		colHits = 0;
		lweLow = 0;
		uweLow = 0;
		waitQuiet(16);
		A = addr;
		nWE = !wr;
		nLDS = ldsN;
		nUDS = udsN;
		nAS = 1'b0;
		#2;
		watchRam(addr, wr, ldsN, udsN);
		n = 0;
		while (RAMReady !== 1'b1) begin
			if (n == ReadyTimeout) failWith("RAMReady never rose for a RAM cycle");
			halfStep();
			watchRam(addr, wr, ldsN, udsN);
			n++;
		end
		n = 0;
		while (colHits == 0) begin
			if (n == ReadyTimeout) failWith("RAM access showed no column phase");
			halfStep();
			watchRam(addr, wr, ldsN, udsN);
			n++;
		end
		if (rowHits == 0) failWith("row address never seen with RAS low and CAS high");
		if (wr) begin
			checkEq("nLWE went low", 32'(lweLow > 0), 32'(!ldsN));
			checkEq("nUWE went low", 32'(uweLow > 0), 32'(!udsN));
		end
		releaseBus();
	endtask

	task automatic watchRom(input logic [AddrHi:AddrLo] addr, input logic wr);
		checkEq("nROMCS", 32'(nROMCS), 0);
		checkEq("nROMWE", 32'(nROMWE), 32'(nAS | !wr));
		checkEq("nOE", 32'(nOE), 32'(nAS | wr));
		checkEq("nRAS", 32'(nRAS), 1);
		checkEq("RAMReady", 32'(RAMReady), 0);
		checkEq("RA8", 32'(RA[8]), 32'(addr[18])); // Flash A18
		checkEq("RA11", 32'(RA[11]), 32'(addr[19])); // Flash A19
	endtask

	task automatic romAccess(input logic [AddrHi:AddrLo] addr, input logic wr);
		waitQuiet(16);
		A = addr;
		nWE = !wr;
		nLDS = 1'b0;
		nUDS = 1'b0;
		nAS = 1'b0;
		#2;
		watchRom(addr, wr);
		repeat (7) begin
			halfStep();
			watchRom(addr, wr);
		end
		releaseBus();
	endtask

	task automatic resetState();
		halfStep();
		checkEq("RAMReady", 32'(RAMReady), 0);
		checkEq("nRAS", 32'(nRAS), 1);
		checkEq("nCAS", 32'(nCAS), 1);
		checkEq("nLWE", 32'(nLWE), 1);
		checkEq("nUWE", 32'(nUWE), 1);
	endtask

	task automatic ramReads(input int count);
		logic [31:0] r;
		repeat (count) begin
			takeBits(RamFree, r);
			ramAccess({{RamSelBits{1'b0}}, r[RamFree-1:0]}, 1'b0, 1'b0, 1'b0);
		end
	endtask

	task automatic byteWrites();
		logic [31:0] r;
		for (int c = 0; c < 4; c++) begin
			takeBits(RamFree, r);
			ramAccess({{RamSelBits{1'b0}}, r[RamFree-1:0]}, 1'b1, c[0], c[1]);
		end
	endtask

	task automatic romAccesses();
		logic [31:0] r;
		for (int w = 0; w < 4; w++) begin
			takeBits(19, r);
			romAccess({RomBase, r[18:0]}, w[0]);
		end
	endtask

	task automatic idleRefresh();
		int casLead;
		int cbr;
		logic prevCas;
		logic prevRas;
		casLead = 0;
		cbr = 0;
		halfStep();
		prevCas = nCAS;
		prevRas = nRAS;
		for (int n = 0; n < 4 * RefPeriod; n++) begin
			halfStep();
			checkEq("RAMReady", 32'(RAMReady), 0);
			if (prevCas && !nCAS && nRAS) casLead++;
			if (prevRas && !nRAS && !nCAS && casLead > 0) cbr++;
			prevCas = nCAS;
			prevRas = nRAS;
		end
		if (cbr == 0) failWith("no CAS-before-RAS refresh on an idle bus");
	endtask

	task automatic heldRefresh();
		int accesses;
		int cbr;
		logic prevCas;
		logic prevRas;
		logic [31:0] r;
		accesses = 0;
		cbr = 0;
		takeBits(RamFree, r);
		waitQuiet(16);
		A = {{RamSelBits{1'b0}}, r[RamFree-1:0]};
		nWE = 1'b1;
		nLDS = 1'b0;
		nUDS = 1'b0;
		nAS = 1'b0;
		#2;
		prevCas = nCAS;
		prevRas = nRAS;
		for (int n = 0; n < 4 * RefPeriod; n++) begin
			halfStep();
			if (prevCas && !nCAS && !nRAS) accesses++; // RAS before CAS marks a normal access
			if (prevRas && !nRAS && !nCAS) cbr++;
			prevCas = nCAS;
			prevRas = nRAS;
		end
		checkEq("column phases in held cycle", 32'(accesses), 1);
		if (cbr == 0) failWith("no refresh ran while the bus cycle was held");
		releaseBus();
	endtask

	initial begin
		lfsr = 32'h2b92787a;
		reset = 1'b1;
		A = '0;
		nAS = 1'b1;
		nWE = 1'b1;
		nLDS = 1'b1;
		nUDS = 1'b1;
		repeat (5) @(posedge CLK);
		@(negedge CLK);
		reset = 1'b0;
		resetState();
		ramReads(8);
		byteWrites();
		romAccesses();
		idleRefresh();
		heldRefresh();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// ==== testbench/MemSubsys_props.sv ====
module MemSubsys_props (
	input logic CLK,
	input logic reset,
	input logic nAS,
	input logic nRAS,
	input logic nCAS,
	input logic nLWE,
	input logic nUWE,
	input logic RAMReady,
	input dramPkg::dramState_t state
);
	import dramPkg::*;

	// Pins parked in the first cycle out of reset
	resetIdle: assert property (@(posedge CLK) $fell(reset) |->
		(!RAMReady && nRAS && nCAS && nLWE && nUWE))
		else $error("DRAM pins not idle after reset");

	// Byte writes only inside a bus cycle and never past the row phase
	noStrayWrite: assert property (@(posedge CLK) disable iff (reset)
		(nAS || (state != Idle && state != AccRow)) |-> (nLWE && nUWE))
		else $error("byte write enable low outside a bus cycle or after the row phase");

	// CBR order has CAS already low when RAS joins
	casFirst: assert property (@(posedge CLK) disable iff (reset)
		(state == RefRas1) |-> (!nCAS && !$past(nCAS)))
		else $error("refresh RAS fell without CAS low first");

endmodule

bind DramCtrl MemSubsys_props i_props (
	.CLK      (CLK),
	.reset    (reset),
	.nAS      (nAS),
	.nRAS     (nRAS),
	.nCAS     (nCAS),
	.nLWE     (nLWE),
	.nUWE     (nUWE),
	.RAMReady (RAMReady),
	.state    (state)
);

// ==== hdl/MemSubsys.sv ====
module MemSubsys (
	input  logic CLK,
	input  logic reset,
	input  logic [busPkg::AddrHi:busPkg::AddrLo] A,
	input  logic nAS,
	input  logic nWE,
	input  logic nLDS,
	input  logic nUDS,
	output logic RAMReady,
	output logic [busPkg::RaWidth-1:0] RA,
	output logic nRAS,
	output logic nCAS,
	output logic nLWE,
	output logic nUWE,
	output logic nOE,
	output logic nROMCS,
	output logic nROMWE
);

	logic BACT;
	logic RAMCS;
	logic ROMCS;
	logic RefReq;
	logic RefUrg;

	AddrDecode i_AddrDecode (
		.CLK   (CLK),
		.reset (reset),
		.A     (A),
		.nAS   (nAS),
		.BACT  (BACT),
		.RAMCS (RAMCS),
		.ROMCS (ROMCS)
	);

	RefreshTimer i_RefreshTimer (
		.CLK    (CLK),
		.reset  (reset),
		.RefReq (RefReq),
		.RefUrg (RefUrg)
	);

	DramCtrl i_DramCtrl (
		.CLK      (CLK),
		.reset    (reset),
		.A        (A),
		.nWE      (nWE),
		.nAS      (nAS),
		.nLDS     (nLDS),
		.nUDS     (nUDS),
		.BACT     (BACT),
		.RAMCS    (RAMCS),
		.ROMCS    (ROMCS),
		.RefReq   (RefReq),
		.RefUrg   (RefUrg),
		.RAMReady (RAMReady),
		.RA       (RA),
		.nRAS     (nRAS),
		.nCAS     (nCAS),
		.nLWE     (nLWE),
		.nUWE     (nUWE),
		.nOE      (nOE),
		.nROMCS   (nROMCS),
		.nROMWE   (nROMWE)
	);

endmodule

// ==== dram/DramCtrl.sv ====
module DramCtrl (
	input  logic CLK,
	input  logic reset,
	// 68000 bus
	input  logic [busPkg::AddrHi:busPkg::AddrLo] A,
	input  logic nWE,
	input  logic nAS,
	input  logic nLDS,
	input  logic nUDS,
	// From the decoder
	input  logic BACT,
	input  logic RAMCS,
	input  logic ROMCS,
	// From the refresh timer
	input  logic RefReq,
	input  logic RefUrg,
	output logic RAMReady,
	// DRAM and flash pins
	output logic [busPkg::RaWidth-1:0] RA,
	output logic nRAS,
	output logic nCAS,
	output logic nLWE,
	output logic nUWE,
	output logic nOE,
	output logic nROMCS,
	output logic nROMWE
);
	import busPkg::*;
	import dramPkg::*;

	dramState_t state;
	dramState_t stateNext;

	logic bactPrev;
	logic RefDone;
	logic refReqLive;
	logic refUrgLive;
	logic ramEn;     // RAM may start an access
	logic once;      // Access already done in this bus cycle
	logic rasSel;    // Column address on RA
	logic casOn;
	logic rasOn;
	logic rasTrail;  // Keeps RAS low into the first half of AccCol
	logic ramStart;
	logic refFromIdle;
	logic refFromCol;
	logic [RaWidth-1:0] rowAddr;
	logic [RaWidth-1:0] colAddr;

	always_ff @(posedge CLK) begin
		if (reset) begin
			bactPrev <= 1'b0;
		end else begin
			bactPrev <= BACT;
		end
	end

	// One refresh per request window
	always_ff @(posedge CLK) begin
		if (reset) begin
			RefDone <= 1'b0;
		end else if (!RefReq && !RefUrg) begin
			RefDone <= 1'b0;
		end else if (state == RefRas1 || state == RefRas2) begin
			RefDone <= 1'b1;
		end
	end

	assign refReqLive = RefReq && !RefDone;
	assign refUrgLive = RefUrg && !RefDone;

	assign ramStart = BACT && RAMCS && ramEn;

	// Slot a refresh into a non-RAM cycle, an idle bus, or a held cycle
	assign refFromIdle = (refReqLive && BACT && !bactPrev && !RAMCS) ||
		(refUrgLive && !BACT) ||
		(refUrgLive && BACT && !ramEn);
	assign refFromCol = refUrgLive;

	always_comb begin
		stateNext = state;
		case (state)
			Idle: begin
				if (ramStart) begin
					stateNext = AccRow;
				end else if (refFromIdle) begin
					stateNext = RefCas;
				end
			end
			AccRow:  stateNext = AccCol;
			AccCol:  stateNext = refFromCol ? RefCas : Recover;
			RefCas:  stateNext = RefRas1;
			RefRas1: stateNext = RefRas2;
			RefRas2: stateNext = RefEnd;
			RefEnd:  stateNext = Recover;
			Recover: stateNext = Idle;
			default: stateNext = Idle;
		endcase
	end

	// Strobe controls registered with the state they belong to
	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= Idle;
			rasSel <= 1'b0;
			casOn <= 1'b0;
			rasOn <= 1'b0;
		end else begin
			state <= stateNext;
			rasSel <= stateNext inside {AccRow, AccCol};
			casOn <= stateNext inside {AccRow, AccCol, RefCas, RefRas1};
			rasOn <= stateNext inside {AccRow, RefRas1, RefRas2};
		end
	end

	// Half-cycle shaping on the falling edge
	always_ff @(negedge CLK) begin
		if (reset) begin
			nCAS <= 1'b1;
			rasTrail <= 1'b0;
		end else begin
			nCAS <= !casOn;
			rasTrail <= (state == AccRow);
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			ramEn <= 1'b1;
		end else if (state == Idle && refFromIdle) begin
			ramEn <= 1'b0;
		end else if (state == AccRow) begin
			ramEn <= 1'b0;
		end else if ((state == Idle || state == Recover) && (!BACT || !once)) begin
			ramEn <= 1'b1; // Bus cycle over or no access yet
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			once <= 1'b0;
		end else if (!BACT) begin
			once <= 1'b0;
		end else if (state == Idle && ramStart) begin
			once <= 1'b1;
		end
	end

	// Ready from the access start until the bus cycle ends
	always_ff @(posedge CLK) begin
		if (reset) begin
			RAMReady <= 1'b0;
		end else if (state == Idle && ramStart) begin
			RAMReady <= 1'b1;
		end else if (!BACT) begin
			RAMReady <= 1'b0;
		end
	end

	// RAS falls straight off nAS so the row is opened before BACT
	assign nRAS = !((!nAS && RAMCS && ramEn) || rasOn || rasTrail);
	assign nOE = !(!nAS && nWE); // Shared with flash
	assign nLWE = !(!nAS && !nWE && !nLDS && ramEn);
	assign nUWE = !(!nAS && !nWE && !nUDS && ramEn);

	assign nROMCS = !ROMCS;
	assign nROMWE = !(!nAS && !nWE);

	// RA11 and RA3 carry the same bits, RA11 has no effect on the array
	assign rowAddr = {A[19], A[17], A[15], A[18], A[14], A[13],
		A[12], A[11], A[19], A[16], A[10], A[9]};
	assign colAddr = {A[20], A[7], A[8], A[21], A[6], A[5],
		A[4], A[3], A[20], A[7], A[2], A[1]};

	assign RA = rasSel ? colAddr : rowAddr; // RA8/RA11 are flash A18/A19 on the row

endmodule

// ==== hdl/RefreshTimer.sv ====
module RefreshTimer (
	input  logic CLK,
	input  logic reset,
	output logic RefReq,
	output logic RefUrg
);
	import dramPkg::*;

	logic [RefCntWidth-1:0] refCnt;
	logic [RefCntWidth-1:0] refCntNext;

	always_comb begin
		if (refCnt == RefCntWidth'(RefPeriod - 1)) begin
			refCntNext = '0; // Start of a new period
		end else begin
			refCntNext = refCnt + 1'b1;
		end
	end

	// Levels track the next count so they change on the same edge as the counter
	always_ff @(posedge CLK) begin
		if (reset) begin
			refCnt <= '0;
			RefReq <= 1'b0;
			RefUrg <= 1'b0;
		end else begin
			refCnt <= refCntNext;
			RefReq <= (refCntNext >= RefCntWidth'(RefReqAt));
			RefUrg <= (refCntNext >= RefCntWidth'(RefUrgAt)); // Must be served now
		end
	end

endmodule

// ==== hdl/AddrDecode.sv ====
module AddrDecode (
	input  logic CLK,
	input  logic reset,
	input  logic [busPkg::AddrHi:busPkg::AddrLo] A,
	input  logic nAS,
	output logic BACT,
	output logic RAMCS,
	output logic ROMCS
);
	import busPkg::*;

	logic [RamSelBits-1:0] ramField;
	logic [$bits(RomBase)-1:0] romField;

	// Bus cycle active, one clock behind the strobe
	always_ff @(posedge CLK) begin
		if (reset) begin
			BACT <= 1'b0;
		end else begin
			BACT <= !nAS;
		end
	end

	assign ramField = A[AddrHi -: RamSelBits];
	assign romField = A[AddrHi -: $bits(RomBase)];

	// Selects follow the address directly
	assign RAMCS = (ramField == '0);
	assign ROMCS = (romField == RomBase); // 1 MB flash window

endmodule

// ==== common/dramPkg.sv ====
package dramPkg;

	// DRAM sequencer states
	// An access runs AccRow, AccCol, Recover
	// A CBR refresh runs RefCas, RefRas1, RefRas2, RefEnd, Recover
	typedef enum logic [2:0] {
		Idle,    // Waiting for a bus cycle or a refresh slot
		AccRow,  // RAS low, column address on RA
		AccCol,  // CAS low on the column
		RefCas,  // CAS goes first for CBR
		RefRas1, // RAS joins CAS
		RefRas2, // RAS held
		RefEnd,  // Both strobes released
		Recover  // Precharge before the next cycle
	} dramState_t;

	// Refresh interval, counted in CLK cycles
	localparam int RefCntWidth = 6;
	localparam int RefPeriod = 64; // Counter wraps here

	// Soft window opens first, urgent window near the end of the period
	localparam int RefReqAt = 40;
	localparam int RefUrgAt = 56;

endpackage

// ==== common/busPkg.sv ====
package busPkg;

	// 68000 word address bus, A0 is folded into nLDS/nUDS
	localparam int AddrHi = 23;
	localparam int AddrLo = 1;

	// Memory map
	// 0x000000 - 0x3FFFFF  DRAM, A[23:22] == 0
	// 0x400000 - 0x4FFFFF  NOR flash, A[23:20] == 4
	// Everything above is left to other decoders

	localparam int RamSelBits = 2; // Upper field that must be zero for RAM

	localparam logic [3:0] RomBase = 4'h4; // A[23:20] for the flash window

	// Multiplexed DRAM address pins, shared with flash A18/A19
	localparam int RaWidth = 12;

endpackage
